// File: run.sh
#!/usr/bin/env bash
# Build and run the frame router testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module frame_router_tb \
    -o Vframe_router_tb \
    -f vlog.f

# The testbench stops with a nonzero status on failure; the log decides.
./obj_dir/Vframe_router_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: source/frame_demux.sv
`timescale 1ns/1ns

module frame_demux (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             enable,

    input  logic                             in_valid,
    output logic                             in_ready,
    input  stream_pkg::in_beat_t             in_data,

    output logic [stream_pkg::M_COUNT-1:0]   out_valid,
    input  logic [stream_pkg::M_COUNT-1:0]   out_ready,
    output stream_pkg::beat_t                out_beat,

    output logic                             drop_done
);

    import stream_pkg::*;

    // frame state
    logic                 frame_reg;
    logic                 drop_reg;
    logic [SEL_WIDTH-1:0] port_reg;
    logic                 drop_done_reg;

    // route of the beat currently offered
    logic [SEL_WIDTH-1:0] port_ctl;
    logic                 drop_ctl;
    logic                 accept;

    route_t               route_in;
    route_t               route_out;
    logic                 slice_in_ready;
    logic                 slice_out_valid;
    logic                 slice_out_ready;
    logic [M_COUNT-1:0]   port_hit;

    // sideband only counts on the first beat of a frame
    assign port_ctl = frame_reg ? port_reg : in_data.select;
    assign drop_ctl = frame_reg ? drop_reg
                                : (in_data.drop || int'(in_data.select) >= M_COUNT);

    // a swallowed frame is not held back by the output side
    assign in_ready = enable && (slice_in_ready || drop_ctl);
    assign accept   = in_valid && in_ready;

    always_comb begin
        route_in.beat = in_data.beat;
        route_in.port = port_ctl;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_reg     <= 1'b0;
            drop_reg      <= 1'b0;
            port_reg      <= '0;
            drop_done_reg <= 1'b0;
        end else begin
            drop_done_reg <= accept && drop_ctl && in_data.beat.last;
            if (accept) begin
                frame_reg <= !in_data.beat.last;
                drop_reg  <= drop_ctl;
                port_reg  <= port_ctl;
            end
        end
    end

    assign drop_done = drop_done_reg;

    stream_skid #(
        .payload_t (route_t)
    ) out_slice (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (accept && !drop_ctl),
        .in_ready  (slice_in_ready),
        .in_data   (route_in),
        .out_valid (slice_out_valid),
        .out_ready (slice_out_ready),
        .out_data  (route_out)
    );

    // one-hot decode of the held port
    always_comb begin
        for (int i = 0; i < M_COUNT; i++) begin
            port_hit[i] = (int'(route_out.port) == i);
        end
    end

    assign out_valid       = slice_out_valid ? port_hit : '0;
    assign slice_out_ready = |(port_hit & out_ready);
    assign out_beat        = route_out.beat;

endmodule

// File: source/frame_router.sv
`timescale 1ns/1ns

module frame_router (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    enable,
    input  logic [stream_pkg::SEL_WIDTH-1:0]                        select,
    input  logic                                                    drop,

    input  logic                                                    in_valid,
    output logic                                                    in_ready,
    input  stream_pkg::beat_t                                       in_beat,

    output logic [stream_pkg::M_COUNT-1:0]                          out_valid,
    input  logic [stream_pkg::M_COUNT-1:0]                          out_ready,
    output stream_pkg::beat_t                                       out_beat,

    output logic [stream_pkg::M_COUNT-1:0][stream_pkg::CNT_WIDTH-1:0] port_frames,
    output logic [stream_pkg::CNT_WIDTH-1:0]                        dropped_frames
);

    import stream_pkg::*;

    in_beat_t in_packed;
    in_beat_t mid_data;
    logic     mid_valid;
    logic     mid_ready;
    logic     slice_ready;
    logic     drop_done;

    // sideband travels with the beat
    assign in_packed = '{beat: in_beat, select: select, drop: drop};

    // intake stalls while disabled
    assign in_ready = slice_ready && enable;

    stream_skid #(
        .payload_t (in_beat_t)
    ) in_slice (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid && enable),
        .in_ready  (slice_ready),
        .in_data   (in_packed),
        .out_valid (mid_valid),
        .out_ready (mid_ready),
        .out_data  (mid_data)
    );

    frame_demux demux (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .in_valid  (mid_valid),
        .in_ready  (mid_ready),
        .in_data   (mid_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat),
        .drop_done (drop_done)
    );

    frame_stats stats (
        .clk            (clk),
        .rst            (rst),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_last       (out_beat.last),
        .drop_done      (drop_done),
        .port_frames    (port_frames),
        .dropped_frames (dropped_frames)
    );

endmodule

// File: source/frame_stats.sv
`timescale 1ns/1ns

module frame_stats (
    input  logic                                                    clk,
    input  logic                                                    rst,

    input  logic [stream_pkg::M_COUNT-1:0]                          out_valid,
    input  logic [stream_pkg::M_COUNT-1:0]                          out_ready,
    input  logic                                                    out_last,
    input  logic                                                    drop_done,

    output logic [stream_pkg::M_COUNT-1:0][stream_pkg::CNT_WIDTH-1:0] port_frames,
    output logic [stream_pkg::CNT_WIDTH-1:0]                        dropped_frames
);

    import stream_pkg::*;

    // frame ends per port this cycle
    logic [M_COUNT-1:0] frame_end;

    assign frame_end = out_valid & out_ready & {M_COUNT{out_last}};

    always_ff @(posedge clk) begin
        if (rst) begin
            port_frames    <= '0;
            dropped_frames <= '0;
        end else begin
            for (int i = 0; i < M_COUNT; i++) begin
                if (frame_end[i]) begin
                    port_frames[i] <= port_frames[i] + 1'b1;
                end
            end
            // counters wrap
            if (drop_done) begin
                dropped_frames <= dropped_frames + 1'b1;
            end
        end
    end

endmodule

// File: source/stream_pkg.sv
package stream_pkg;

    // number of output ports
    localparam int M_COUNT = 3;

    // port select width, wide enough to name a port that does not exist
    localparam int SEL_WIDTH = 2;

    // statistics counters wrap at this width
    localparam int CNT_WIDTH = 16;

    // one byte-wide stream beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } beat_t;

    // input beat with the routing sideband sampled at frame start
    typedef struct packed {
        beat_t                beat;
        logic [SEL_WIDTH-1:0] select;
        logic                 drop;
    } in_beat_t;

    // beat with its resolved destination port
    typedef struct packed {
        beat_t                beat;
        logic [SEL_WIDTH-1:0] port;
    } route_t;

endpackage

// File: source/stream_skid.sv
`timescale 1ns/1ns

module stream_skid #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     out_valid_reg;
    logic     temp_valid_reg;
    logic     in_ready_reg;
    payload_t out_data_reg;
    payload_t temp_data_reg;

    logic in_xfer;
    logic out_xfer;
    logic ready_early;
    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    assign in_ready  = in_ready_reg;
    assign out_valid = out_valid_reg;
    assign out_data  = out_data_reg;

    assign in_xfer  = in_valid && in_ready_reg;
    assign out_xfer = out_valid_reg && out_ready;

    // stay ready unless the temp register is about to fill
    assign ready_early = out_xfer || (!temp_valid_reg && (!out_valid_reg || !in_xfer));

    assign store_in_to_out   = in_xfer && (out_xfer || !out_valid_reg);
    assign store_in_to_temp  = in_xfer && out_valid_reg && !out_xfer;
    assign store_temp_to_out = !in_xfer && out_xfer;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg  <= 1'b0;
            temp_valid_reg <= 1'b0;
            in_ready_reg   <= 1'b0;
        end else begin
            in_ready_reg <= ready_early;
            if (store_in_to_out) begin
                out_valid_reg <= 1'b1;
            end else if (store_in_to_temp) begin
                temp_valid_reg <= 1'b1;
            end else if (store_temp_to_out) begin
                // temp drains into the output, or output goes empty
                out_valid_reg  <= temp_valid_reg;
                temp_valid_reg <= 1'b0;
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_data_reg <= in_data;
        end else if (store_temp_to_out) begin
            out_data_reg <= temp_data_reg;
        end
        if (store_in_to_temp) begin
            temp_data_reg <= in_data;
        end
    end

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 16;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset drops on a falling edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: tests/frame_router_tb.sv
`timescale 1ns/1ns

module frame_router_tb;

    import stream_pkg::*;

    localparam int N_FRAMES   = 200;
    localparam int MAX_LEN    = 6;
    localparam int DRAIN_TAIL = 10;
    // 16 cycles of 4 ns for every possible beat
    localparam longint WATCHDOG_NS = longint'(N_FRAMES) * MAX_LEN * 16 * 4;

    logic                              clk;
    logic                              rst;
    logic                              enable;
    logic [SEL_WIDTH-1:0]              select;
    logic                              drop;
    logic                              in_valid;
    logic                              in_ready;
    beat_t                             in_beat;
    logic [M_COUNT-1:0]                out_valid;
    logic [M_COUNT-1:0]                out_ready;
    beat_t                             out_beat;
    logic [M_COUNT-1:0][CNT_WIDTH-1:0] port_frames;
    logic [CNT_WIDTH-1:0]              dropped_frames;

    logic [31:0]          lfsr_state;
    // one queue of expected beats per port
    beat_t                exp_q[M_COUNT][$];
    int                   model_frames[M_COUNT];
    int                   model_dropped;
    int                   frames_sent;
    int                   beat_idx;
    int                   frame_len;
    logic [SEL_WIDTH-1:0] frame_sel;
    logic                 frame_drop;
    logic                 frame_dropped;
    logic [SEL_WIDTH-1:0] frame_port;
    logic                 holding;
    logic                 draining;

    clock_gen clocks (
        .clk (clk),
        .rst (rst)
    );

    frame_router dut (
        .clk            (clk),
        .rst            (rst),
        .enable         (enable),
        .select         (select),
        .drop           (drop),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_beat        (in_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_beat       (out_beat),
        .port_frames    (port_frames),
        .dropped_frames (dropped_frames)
    );

    // fibonacci lfsr with taps 32 22 2 1, stepped once per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic int pending_beats();
        int total;
        total = 0;
        for (int i = 0; i < M_COUNT; i++) begin
            total += exp_q[i].size();
        end
        return total;
    endfunction

    task automatic stop_on_error();
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_idle();
        assert (in_ready == 1'b0 && out_valid == '0) else begin
            $display("[FAIL] %0t in_ready/out_valid: got %b/%b expected 0/000",
                     $time, in_ready, out_valid);
            stop_on_error();
        end
        assert (port_frames == '0 && dropped_frames == '0) else begin
            $display("[FAIL] %0t port_frames/dropped_frames: got %h/%h expected 0/0",
                     $time, port_frames, dropped_frames);
            stop_on_error();
        end
    endtask

    task automatic drive_inputs();
        if (!holding) begin
            if (!draining && take_bits(2) != 0) begin
                if (beat_idx == 0) begin
                    frame_len  = 1 + int'(take_bits(3) % MAX_LEN);
                    frame_sel  = SEL_WIDTH'(take_bits(SEL_WIDTH));
                    frame_drop = (take_bits(3) == 0);
                end
                in_beat.data = 8'(take_bits(8));
                in_beat.user = 1'(take_bits(1));
                in_beat.last = (beat_idx == frame_len - 1);
                in_valid     = 1'b1;
                holding      = 1'b1;
            end else begin
                in_valid = 1'b0;
            end
        end
        // sideband noise except on a held first beat
        if (holding && beat_idx == 0) begin
            select = frame_sel;
            drop   = frame_drop;
        end else begin
            select = SEL_WIDTH'(take_bits(SEL_WIDTH));
            drop   = (take_bits(3) == 0);
        end
        if (draining) begin
            enable    = 1'b1;
            out_ready = '1;
        end else begin
            enable = (take_bits(3) != 0);
            for (int i = 0; i < M_COUNT; i++) begin
                out_ready[i] = (take_bits(2) != 0);
            end
        end
    endtask

    task automatic check_outputs();
        beat_t expected;
        assert ($onehot0(out_valid)) else begin
            $display("[FAIL] %0t out_valid: got %b expected at most one bit set",
                     $time, out_valid);
            stop_on_error();
        end
        assert (enable || !(in_valid && in_ready)) else begin
            $display("input handshake at %0t while enable was low", $time);
            stop_on_error();
        end
        for (int i = 0; i < M_COUNT; i++) begin
            if (out_valid[i] && out_ready[i]) begin
                assert (exp_q[i].size() > 0) else begin
                    $display("port %0d delivered a beat at %0t with none expected", i, $time);
                    stop_on_error();
                end
                expected = exp_q[i].pop_front();
                assert (out_beat == expected) else begin
                    $display("[FAIL] %0t out_beat port %0d: got %h/%b/%b expected %h/%b/%b",
                             $time, i, out_beat.data, out_beat.last, out_beat.user,
                             expected.data, expected.last, expected.user);
                    stop_on_error();
                end
            end
        end
    endtask

    task automatic record_input();
        if (in_valid && in_ready) begin
            // routing is fixed by the first beat only
            if (beat_idx == 0) begin
                frame_dropped = drop || (int'(select) >= M_COUNT);
                frame_port    = select;
            end
            if (!frame_dropped) begin
                exp_q[frame_port].push_back(in_beat);
            end
            holding = 1'b0;
            beat_idx++;
            if (in_beat.last) begin
                if (frame_dropped) begin
                    model_dropped++;
                end else begin
                    model_frames[frame_port]++;
                end
                beat_idx = 0;
                frames_sent++;
            end
        end
    endtask

    task automatic run_cycle();
        @(negedge clk);
        drive_inputs();
        // inputs and registered outputs hold from here to the rising edge
        #1;
        check_outputs();
        record_input();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
        stop_on_error();
    end

    initial begin
        int reset_cycles;
        lfsr_state    = 32'h6f3edd71;
        enable        = 1'b0;
        select        = '0;
        drop          = 1'b0;
        in_valid      = 1'b0;
        in_beat       = '0;
        out_ready     = '0;
        model_dropped = 0;
        frames_sent   = 0;
        beat_idx      = 0;
        frame_len     = 1;
        holding       = 1'b0;
        draining      = 1'b0;
        foreach (model_frames[i]) begin
            model_frames[i] = 0;
        end

        // no rising edge has cleared the registers before the first pass
        // the last pass lands in the first cycle after reset
        reset_cycles = 0;
        do begin
            @(negedge clk);
            #1;
            reset_cycles++;
            if (reset_cycles > 1) begin
                check_idle();
            end
        end while (rst);

        while (frames_sent < N_FRAMES) begin
            run_cycle();
        end
        draining = 1'b1;
        while (pending_beats() != 0) begin
            run_cycle();
        end
        repeat (DRAIN_TAIL) run_cycle();

        for (int i = 0; i < M_COUNT; i++) begin
            assert (port_frames[i] == CNT_WIDTH'(model_frames[i])) else begin
                $display("[FAIL] %0t port_frames[%0d]: got %0d expected %0d",
                         $time, i, port_frames[i], model_frames[i]);
                stop_on_error();
            end
        end
        assert (dropped_frames == CNT_WIDTH'(model_dropped)) else begin
            $display("[FAIL] %0t dropped_frames: got %0d expected %0d",
                     $time, dropped_frames, model_dropped);
            stop_on_error();
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: vlog.f
source/stream_pkg.sv
source/stream_skid.sv
source/frame_demux.sv
source/frame_stats.sv
source/frame_router.sv
tests/clock_gen.sv
tests/frame_router_tb.sv
